// File: hw/tdc_pkg.sv
// ********************
// Shared TDC definitions
// Event word type, register map, config bit positions,
// width and trigger distance limit codes
// ********************

package tdc_pkg;

    // [31:28] identifier, [27:12] count or timestamp, [11:0] width
    typedef logic [31:0] event_word_t;

    // Wishbone register map
    localparam logic [2:0] ADDR_VERSION = 3'd0;  // Write here is soft reset
    localparam logic [2:0] ADDR_CONFIG  = 3'd1;
    localparam logic [2:0] ADDR_EVCNT0  = 3'd2;  // Read latches whole count
    localparam logic [2:0] ADDR_EVCNT1  = 3'd3;
    localparam logic [2:0] ADDR_EVCNT2  = 3'd4;
    localparam logic [2:0] ADDR_EVCNT3  = 3'd5;
    localparam logic [2:0] ADDR_LOST    = 3'd6;

    localparam logic [7:0] TDC_VERSION = 8'd2;

    // Configuration register bits
    localparam int CFG_EN                = 0;
    localparam int CFG_EN_EXT            = 1;  // Enable follows ext_en
    localparam int CFG_EN_ARM            = 2;
    localparam int CFG_WRITE_TS          = 3;
    localparam int CFG_TRIG_DIST         = 4;
    localparam int CFG_NO_WRITE_TRIG_ERR = 5;

    localparam int unsigned WIDTH_MAX = 4095;  // 12-bit width ceiling

    localparam logic [7:0] TDIST_NONE = 8'd255;  // No or bad trigger
    localparam logic [7:0] TDIST_OVF  = 8'd254;  // Distance saturated

endpackage

// File: hw/sample_edge_decoder.sv
// ********************
// Rising edge decoder for one sample word
// Edge position, high samples, ambiguity flag
// ********************
`timescale 1ns/1ns

module sample_edge_decoder #(
    parameter int SAMPLES_PER_WORD = 16
) (
    input  logic                        DV_CLK,
    input  logic                        RST_SYNC,
    input  logic [SAMPLES_PER_WORD-1:0] samples,
    output logic                        found,
    output logic [4:0]                  pos,
    output logic [4:0]                  ones,
    output logic                        err
);

    logic                      prev_bit0;  // Latest sample of last word
    logic [SAMPLES_PER_WORD:0] ext;
    logic [4:0]                all_ones;

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            prev_bit0 <= 1'b0;
        end else begin
            prev_bit0 <= samples[0];
        end
    end

    assign ext = {prev_bit0, samples};  // Top bit is the earlier neighbour

    // Walk from the latest sample towards the earliest
    always_comb begin
        found    = 1'b0;
        pos      = '0;
        ones     = '0;
        all_ones = '0;
        for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
            all_ones = all_ones + 5'(ext[i]);
            if (!found) begin
                ones = ones + 5'(ext[i]);
                if (ext[i] && !ext[i+1]) begin
                    found = 1'b1;
                    pos   = 5'(i + 1);
                end
            end
        end
    end

    assign err = found && (all_ones != ones);  // High samples before the edge

endmodule

// File: hw/pulse_width_fsm.sv
// ********************
// Hit pulse measurement FSM
// Idle/armed/count states, saturating width,
// event counter and start timestamp
// ********************
`timescale 1ns/1ns

module pulse_width_fsm #(
    parameter int SAMPLES_PER_WORD = 16
) (
    input  logic        DV_CLK,
    input  logic        RST_SYNC,
    input  logic        enable,
    input  logic        arm_mode,
    input  logic        arm,
    input  logic        hit_found,
    input  logic [4:0]  hit_ones,
    input  logic        hit_err,
    input  logic        hit_all_high,
    input  logic [15:0] timestamp,
    output logic        start,
    output logic        finish,
    output logic [11:0] width,
    output logic [31:0] event_count,
    output logic [15:0] event_ts
);
    import tdc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        COUNT
    } state_t;

    state_t      state;
    state_t      next_state;
    logic        arm_d;
    logic        arm_rise;
    logic [11:0] acc;       // Width so far
    logic        err_seen;
    logic [12:0] sum;
    logic [11:0] width_sat;
    logic        err_now;

    assign arm_rise = arm && !arm_d;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (enable && !arm_mode && hit_found) begin
                    next_state = COUNT;
                end else if (enable && arm_mode && arm_rise) begin
                    next_state = ARMED;
                end
            end
            ARMED: begin
                if (!enable) begin
                    next_state = IDLE;
                end else if (hit_found) begin
                    next_state = COUNT;
                end
            end
            COUNT: begin
                if (!hit_all_high || !enable) begin  // A zero sample ends the pulse
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    assign start  = (state != COUNT) && (next_state == COUNT);
    assign finish = (state == COUNT) && (next_state == IDLE);

    // Current word added on top of the running width
    assign sum       = ((state == COUNT) ? {1'b0, acc} : 13'd0) + 13'(hit_ones);
    assign width_sat = (sum > 13'(WIDTH_MAX)) ? 12'(WIDTH_MAX) : sum[11:0];
    assign err_now   = hit_err || ((state == COUNT) && err_seen);
    assign width     = err_now ? 12'd0 : width_sat;

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            state       <= IDLE;
            arm_d       <= 1'b0;
            event_count <= '0;
        end else begin
            state <= next_state;
            arm_d <= arm;
            if (finish) begin
                event_count <= event_count + 32'd1;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (start) begin
            acc      <= width_sat;
            err_seen <= hit_err;
            event_ts <= timestamp;
        end else if (state == COUNT) begin
            acc      <= width_sat;
            err_seen <= err_now;
        end
    end

endmodule

// File: hw/trigger_distance.sv
// ********************
// Hit edge to trigger edge distance
// Saturates at the overflow code, error code otherwise
// ********************
`timescale 1ns/1ns

module trigger_distance #(
    parameter int SAMPLES_PER_WORD = 16
) (
    input  logic       DV_CLK,
    input  logic       RST_SYNC,
    input  logic       start,
    input  logic       finish,
    input  logic       counting,
    input  logic       hit_found,
    input  logic [4:0] hit_pos,
    input  logic       hit_err,
    input  logic       trig_found,
    input  logic [4:0] trig_pos,
    input  logic       trig_err,
    output logic [7:0] distance
);
    import tdc_pkg::*;

    // Past this the result is sure to overflow, so stop adding
    localparam logic [8:0] ACC_HOLD = 9'(TDIST_OVF) + 9'(SAMPLES_PER_WORD);

    logic       tracking;
    logic       tracking_next;
    logic [8:0] acc;        // Hit position plus whole words up to this one
    logic [8:0] acc_next;
    logic [7:0] dist_q;
    logic [7:0] dist_next;
    logic [8:0] trig_dist;

    assign trig_dist = acc - 9'(trig_pos);

    always_comb begin
        tracking_next = tracking;
        acc_next      = acc;
        dist_next     = dist_q;
        if (start && hit_found) begin
            acc_next      = 9'(hit_pos) + 9'(SAMPLES_PER_WORD);  // Base for the next word
            tracking_next = 1'b0;
            if (hit_err || trig_err) begin
                dist_next = TDIST_NONE;
            end else if (trig_found) begin
                // Lower position is later in time
                dist_next = (trig_pos <= hit_pos) ? 8'(hit_pos - trig_pos) : TDIST_NONE;
            end else begin
                dist_next     = TDIST_NONE;
                tracking_next = 1'b1;
            end
        end else if (counting) begin
            if (hit_err || trig_err) begin
                dist_next     = TDIST_NONE;
                tracking_next = 1'b0;
            end else if (trig_found) begin
                tracking_next = 1'b0;
                if (!tracking) begin
                    dist_next = TDIST_NONE;  // Second trigger
                end else if (trig_dist > 9'(TDIST_OVF)) begin
                    dist_next = TDIST_OVF;
                end else begin
                    dist_next = trig_dist[7:0];
                end
            end else if (tracking && (acc <= ACC_HOLD)) begin
                acc_next = acc + 9'(SAMPLES_PER_WORD);
            end
        end else begin
            dist_next     = TDIST_NONE;
            tracking_next = 1'b0;
        end
    end

    assign distance = dist_next;  // Includes a trigger in the ending word

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || finish) begin
            dist_q   <= TDIST_NONE;
            tracking <= 1'b0;
        end else begin
            dist_q   <= dist_next;
            tracking <= tracking_next;
        end
    end

    always_ff @(posedge DV_CLK) begin
        acc <= acc_next;
    end

endmodule

// File: hw/event_fifo.sv
// ********************
// Show-ahead event word FIFO
// Single clock, occupancy counter
// ********************
`timescale 1ns/1ns

module event_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                DV_CLK,
    input  logic                RST_SYNC,
    input  logic                write,
    input  tdc_pkg::event_word_t wdata,
    output logic                full,
    input  logic                read,
    output logic                empty,
    output tdc_pkg::event_word_t rdata
);
    import tdc_pkg::*;

    localparam int AW = $clog2(DEPTH);

    event_word_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_write;
    logic          do_read;

    assign full     = (count == (AW+1)'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = write && !full;
    assign do_read  = read && !empty;  // Read on empty is dropped
    assign rdata    = mem[rd_ptr];     // Head word always visible

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(do_write) - (AW+1)'(do_read);
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// File: hw/tdc_wb_regs.sv
// ********************
// Wishbone classic register block
// Version, configuration, event count snapshot,
// lost count, soft reset pulse
// ********************
`timescale 1ns/1ns

module tdc_wb_regs (
    input  logic        DV_CLK,
    input  logic        RST_SYNC,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [7:0]  wb_dat_w,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack,
    input  logic [31:0] event_count,
    input  logic [7:0]  lost_count,
    output logic [7:0]  cfg,
    output logic        soft_rst
);
    import tdc_pkg::*;

    logic        req;
    logic        wr_req;
    logic        rd_req;
    logic [31:0] evcnt_snap;

    assign req    = wb_cyc && wb_stb && !wb_ack;  // New cycle, not yet acked
    assign wr_req = req && wb_we;
    assign rd_req = req && !wb_we;

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            wb_ack   <= 1'b0;
            soft_rst <= 1'b0;
        end else begin
            wb_ack   <= req;
            soft_rst <= wr_req && (wb_adr == ADDR_VERSION);  // High with the ack
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || soft_rst) begin
            cfg        <= '0;
            evcnt_snap <= '0;
        end else begin
            if (wr_req && (wb_adr == ADDR_CONFIG)) begin
                cfg <= wb_dat_w;
            end
            if (rd_req && (wb_adr == ADDR_EVCNT0)) begin
                evcnt_snap <= event_count;  // Upper bytes read from here
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (rd_req) begin
            case (wb_adr)
                ADDR_VERSION: wb_dat_r <= TDC_VERSION;
                ADDR_CONFIG:  wb_dat_r <= cfg;
                ADDR_EVCNT0:  wb_dat_r <= event_count[7:0];
                ADDR_EVCNT1:  wb_dat_r <= evcnt_snap[15:8];
                ADDR_EVCNT2:  wb_dat_r <= evcnt_snap[23:16];
                ADDR_EVCNT3:  wb_dat_r <= evcnt_snap[31:24];
                ADDR_LOST:    wb_dat_r <= lost_count;
                default:      wb_dat_r <= 8'd0;
            endcase
        end
    end

endmodule

// File: hw/tdc_top.sv
// ********************
// TDC top level
// Decoders, measurement, event packing,
// lost counter, FIFO and register block
// ********************
`timescale 1ns/1ns

module tdc_top #(
    parameter int         SAMPLES_PER_WORD = 16,
    parameter logic [3:0] DATA_IDENTIFIER  = 4'd4,
    parameter int         FIFO_DEPTH       = 16
) (
    input  logic                        DV_CLK,
    input  logic                        RST_SYNC,
    input  logic [SAMPLES_PER_WORD-1:0] hit_samples,
    input  logic [SAMPLES_PER_WORD-1:0] trig_samples,
    input  logic [15:0]                 timestamp,
    input  logic                        arm,
    input  logic                        ext_en,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [2:0]                  wb_adr,
    input  logic [7:0]                  wb_dat_w,
    output logic [7:0]                  wb_dat_r,
    output logic                        wb_ack,
    input  logic                        fifo_read,
    output logic                        fifo_empty,
    output logic [31:0]                 fifo_data
);
    import tdc_pkg::*;

    logic        rst_int;
    logic        soft_rst;
    logic [7:0]  cfg;
    logic        enable;
    logic        hit_found, hit_err, trig_found, trig_err;
    logic [4:0]  hit_pos, hit_ones, trig_pos;
    logic        start, finish, in_event;
    logic [11:0] width;
    logic [31:0] event_count;
    logic [15:0] event_ts;
    logic [7:0]  distance;
    logic [7:0]  lost_count;
    event_word_t event_word;
    logic        suppress, fifo_full, fifo_write;

    assign rst_int = RST_SYNC || soft_rst;
    assign enable  = cfg[CFG_EN] || (cfg[CFG_EN_EXT] && ext_en);

    sample_edge_decoder #(.SAMPLES_PER_WORD(SAMPLES_PER_WORD)) hit_decoder_i (
        .DV_CLK(DV_CLK), .RST_SYNC(rst_int), .samples(hit_samples),
        .found(hit_found), .pos(hit_pos), .ones(hit_ones), .err(hit_err)
    );

    // Trigger ones count is not needed, only the edge
    sample_edge_decoder #(.SAMPLES_PER_WORD(SAMPLES_PER_WORD)) trig_decoder_i (
        .DV_CLK(DV_CLK), .RST_SYNC(rst_int), .samples(trig_samples),
        .found(trig_found), .pos(trig_pos), .ones(), .err(trig_err)
    );

    pulse_width_fsm #(.SAMPLES_PER_WORD(SAMPLES_PER_WORD)) pulse_width_fsm_i (
        .DV_CLK(DV_CLK), .RST_SYNC(rst_int), .enable(enable),
        .arm_mode(cfg[CFG_EN_ARM]), .arm(arm), .hit_found(hit_found),
        .hit_ones(hit_ones), .hit_err(hit_err), .hit_all_high(&hit_samples),
        .timestamp(timestamp), .start(start), .finish(finish), .width(width),
        .event_count(event_count), .event_ts(event_ts)
    );

    // Mirrors the FSM count state
    always_ff @(posedge DV_CLK) begin
        if (rst_int || finish) begin
            in_event <= 1'b0;
        end else if (start) begin
            in_event <= 1'b1;
        end
    end

    trigger_distance #(.SAMPLES_PER_WORD(SAMPLES_PER_WORD)) trigger_distance_i (
        .DV_CLK(DV_CLK), .RST_SYNC(rst_int), .start(start), .finish(finish),
        .counting(in_event), .hit_found(hit_found), .hit_pos(hit_pos),
        .hit_err(hit_err), .trig_found(trig_found), .trig_pos(trig_pos),
        .trig_err(trig_err), .distance(distance)
    );

    always_comb begin
        event_word = {DATA_IDENTIFIER, (cfg[CFG_WRITE_TS] ? event_ts : event_count[15:0]), width};
        if (cfg[CFG_TRIG_DIST]) begin
            event_word[27:20] = distance;  // Overlays top of count field
        end
    end

    assign suppress   = cfg[CFG_TRIG_DIST] && cfg[CFG_NO_WRITE_TRIG_ERR]
                        && (distance == TDIST_NONE);
    assign fifo_write = finish && !fifo_full && !suppress;

    always_ff @(posedge DV_CLK) begin
        if (rst_int) begin
            lost_count <= '0;
        end else if (finish && fifo_full && !suppress && (lost_count != 8'hFF)) begin
            lost_count <= lost_count + 8'd1;
        end
    end

    event_fifo #(.DEPTH(FIFO_DEPTH)) event_fifo_i (
        .DV_CLK(DV_CLK), .RST_SYNC(rst_int), .write(fifo_write), .wdata(event_word),
        .full(fifo_full), .read(fifo_read), .empty(fifo_empty), .rdata(fifo_data)
    );

    tdc_wb_regs tdc_wb_regs_i (
        .DV_CLK(DV_CLK), .RST_SYNC(RST_SYNC), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .event_count(event_count), .lost_count(lost_count),
        .cfg(cfg), .soft_rst(soft_rst)
    );

endmodule

// File: verification/tdc_assertions.sv
// ********************
// Bus handshake and FIFO flag assertions
// Bound into the TDC top level
// ********************
`timescale 1ns/1ns

module tdc_assertions (
    input logic DV_CLK,
    input logic RST_SYNC,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic fifo_empty
);

    // Ack only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge DV_CLK) disable iff (RST_SYNC)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack high outside a bus cycle");

    ack_one_cycle: assert property (@(posedge DV_CLK) disable iff (RST_SYNC)
        wb_ack |=> !wb_ack)
        else $error("wb_ack longer than one cycle");

    empty_after_reset: assert property (@(posedge DV_CLK)
        RST_SYNC |=> fifo_empty)
        else $error("fifo_empty low after reset");

endmodule

bind tdc_top tdc_assertions assertions_i (
    .DV_CLK(DV_CLK), .RST_SYNC(RST_SYNC), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_ack(wb_ack), .fifo_empty(fifo_empty)
);

// File: verification/tdc_tb.sv
// ********************
// Directed TDC testbench
// Clock, reset, bus and sample drivers, checks, timeout
// ********************
`timescale 1ns/1ns

module tdc_tb;

    localparam int MAX_CYCLES = 3000;  // Several times the full run

    logic        DV_CLK = 1'b0;
    logic        RST_SYNC = 1'b1;
    logic [15:0] hit_samples = '0;
    logic [15:0] trig_samples = '0;
    logic [15:0] timestamp = '0;
    logic        arm = 1'b0;
    logic        ext_en = 1'b0;
    logic        wb_cyc = 1'b0;
    logic        wb_stb = 1'b0;
    logic        wb_we = 1'b0;
    logic [2:0]  wb_adr = '0;
    logic [7:0]  wb_dat_w = '0;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic        fifo_read = 1'b0;
    logic        fifo_empty;
    logic [31:0] fifo_data;

    integer      seed = 38565;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    logic [15:0] ts_next = 16'h0100;
    logic [15:0] start_ts;            // Timestamp sent with the edge word

    tdc_top #(.SAMPLES_PER_WORD(16), .DATA_IDENTIFIER(4'd4), .FIFO_DEPTH(16)) dut_i (
        .DV_CLK(DV_CLK), .RST_SYNC(RST_SYNC), .hit_samples(hit_samples),
        .trig_samples(trig_samples), .timestamp(timestamp), .arm(arm), .ext_en(ext_en),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .fifo_read(fifo_read), .fifo_empty(fifo_empty), .fifo_data(fifo_data)
    );

    initial begin
        forever #4 DV_CLK = ~DV_CLK;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge DV_CLK);
            cycles++;
        end
        $display("Run stopped, no finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] event_word(input logic [15:0] field,
                                               input logic [11:0] width);
        return {4'd4, field, width};
    endfunction

    task automatic wb_access(input logic we, input logic [2:0] adr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(posedge DV_CLK);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(negedge DV_CLK);
            waited++;
        end while (!wb_ack && waited < 20);
        if (!wb_ack) begin
            $display("Bus access to address %0d got no acknowledge", adr);
            errors++;
        end
        rdata = wb_dat_r;
        @(posedge DV_CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [7:0] data);
        logic [7:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [7:0] data);
        wb_access(1'b0, adr, 8'h00, data);
    endtask

    task automatic drive_word(input logic [15:0] hit, input logic [15:0] trig);
        @(posedge DV_CLK);
        hit_samples  <= hit;
        trig_samples <= trig;
        timestamp    <= ts_next;
        ts_next       = ts_next + 16'd13;
    endtask

    // Bit 15 is the earliest sample of a word; trigger pulses are 2 samples
    task automatic send_pulse(input int start_offset, input int length, input int trig_offset);
        int          nwords;
        int          t;
        logic [15:0] hw;
        logic [15:0] tw;
        nwords = (start_offset + length + 15) / 16 + 1;
        for (int k = 0; k < nwords; k++) begin
            for (int j = 0; j < 16; j++) begin
                t = k * 16 + j;
                hw[15-j] = (t >= start_offset) && (t < start_offset + length);
                tw[15-j] = (trig_offset >= 0) && (t >= trig_offset) && (t < trig_offset + 2);
            end
            if (k == start_offset / 16) begin
                start_ts = ts_next;
            end
            drive_word(hw, tw);
        end
        drive_word(16'h0000, 16'h0000);
    endtask

    task automatic wait_event();
        int waited;
        waited = 0;
        @(negedge DV_CLK);
        while (fifo_empty && waited < 40) begin
            @(negedge DV_CLK);
            waited++;
        end
        if (fifo_empty) begin
            $display("Expected event word never reached the FIFO");
            errors++;
        end
    endtask

    task automatic pop_event(output logic [31:0] data);
        @(negedge DV_CLK);
        check_value("fifo_empty", fifo_empty, 1'b0);
        data = fifo_data;
        @(posedge DV_CLK);
        fifo_read <= 1'b1;
        @(posedge DV_CLK);
        fifo_read <= 1'b0;
    endtask

    task automatic expect_event(input logic [31:0] exp);
        logic [31:0] word;
        wait_event();
        pop_event(word);
        check_value("fifo_data", word, exp);
    endtask

    task automatic expect_empty();
        repeat (4) @(negedge DV_CLK);
        check_value("fifo_empty", fifo_empty, 1'b1);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    task automatic test_registers();
        int         e0;
        logic [7:0] rd;
        e0 = errors;
        wb_read(3'd0, rd);
        check_value("version", rd, 8'd2);
        wb_write(3'd1, 8'h3A);
        wb_read(3'd1, rd);
        check_value("config", rd, 8'h3A);
        wb_write(3'd0, 8'h00);   // Soft reset
        wb_read(3'd1, rd);
        check_value("config", rd, 8'h00);
        finish_test("registers", e0);
    endtask

    task automatic test_free_running();
        int e0;
        int len;
        int off;
        e0 = errors;
        wb_write(3'd0, 8'h00);
        wb_write(3'd1, 8'h01);
        for (int n = 0; n < 10; n++) begin
            len = 1 + ($unsigned($random(seed)) % 200);
            off = $unsigned($random(seed)) % 16;
            send_pulse(off, len, -1);
            expect_event(event_word(16'(n), 12'(len)));
        end
        drive_word(16'h0E70, 16'h0000);  // Two edges in one word
        drive_word(16'h0000, 16'h0000);
        expect_event(event_word(16'd10, 12'd0));
        finish_test("free running widths", e0);
    endtask

    task automatic test_timestamp();
        int e0;
        e0 = errors;
        wb_write(3'd0, 8'h00);
        wb_write(3'd1, 8'h09);
        send_pulse(5, 37, -1);
        expect_event(event_word(start_ts, 12'd37));
        send_pulse(0, 5000, -1);
        expect_event(event_word(start_ts, 12'd4095));
        finish_test("timestamp and saturation", e0);
    endtask

    task automatic test_armed();
        int         e0;
        logic [7:0] rd;
        e0 = errors;
        wb_write(3'd0, 8'h00);
        wb_write(3'd1, 8'h05);
        send_pulse(4, 30, -1);
        expect_empty();
        @(posedge DV_CLK);
        arm <= 1'b1;
        @(posedge DV_CLK);
        arm <= 1'b0;
        send_pulse(4, 30, -1);
        expect_event(event_word(16'd0, 12'd30));
        wb_write(3'd1, 8'h02);            // External enable only
        @(posedge DV_CLK);
        ext_en <= 1'b1;
        fork
            send_pulse(0, 200, -1);
            begin
                repeat (4) @(posedge DV_CLK);
                ext_en <= 1'b0;           // Drops with the fourth word
            end
        join
        expect_event(event_word(16'd1, 12'd64));
        wb_read(3'd2, rd);
        check_value("evcnt byte0", rd, 8'd2);
        for (int b = 1; b < 4; b++) begin
            wb_read(3'(2 + b), rd);
            check_value("evcnt upper byte", rd, 8'd0);
        end
        finish_test("armed mode", e0);
    endtask

    task automatic test_trigger();
        int e0;
        e0 = errors;
        wb_write(3'd0, 8'h00);
        wb_write(3'd1, 8'h11);
        send_pulse(2, 40, 7);
        expect_event({4'd4, 8'd5, 8'd0, 12'd40});
        send_pulse(2, 40, -1);
        expect_event({4'd4, 8'hFF, 8'd1, 12'd40});
        wb_write(3'd1, 8'h31);
        send_pulse(2, 40, -1);
        expect_empty();
        send_pulse(2, 40, 10);
        expect_event({4'd4, 8'd8, 8'd3, 12'd40});
        send_pulse(2, 40, 30);
        expect_event({4'd4, 8'd28, 8'd4, 12'd40});  // Trigger in the next word
        finish_test("trigger distance", e0);
    endtask

    task automatic test_backpressure();
        int          e0;
        logic [7:0]  rd;
        logic [31:0] word;
        e0 = errors;
        wb_write(3'd0, 8'h00);
        wb_write(3'd1, 8'h01);
        for (int n = 0; n < 20; n++) begin
            send_pulse(3, 20, -1);
        end
        wb_read(3'd6, rd);
        check_value("lost_count", rd, 8'd4);
        for (int n = 0; n < 16; n++) begin
            pop_event(word);
            check_value("fifo_data", word, event_word(16'(n), 12'd20));
        end
        expect_empty();
        wb_write(3'd0, 8'h00);            // Soft reset clears the lost count
        wb_read(3'd6, rd);
        check_value("lost_count", rd, 8'h00);
        finish_test("back-pressure", e0);
    endtask

    initial begin
        repeat (2) @(posedge DV_CLK);
        RST_SYNC <= 1'b0;
        test_registers();
        test_free_running();
        test_timestamp();
        test_armed();
        test_trigger();
        test_backpressure();
        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hw/tdc_pkg.sv
hw/sample_edge_decoder.sv
hw/pulse_width_fsm.sv
hw/trigger_distance.sv
hw/event_fifo.sv
hw/tdc_wb_regs.sv
hw/tdc_top.sv
verification/tdc_assertions.sv
verification/tdc_tb.sv

// File: Makefile
# Verilator build and run for the TDC testbench

VERILATOR   ?= verilator
TOP         ?= tdc_tb
FILELIST    ?= list.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --assert -Wno-fatal
PASS_STRING ?= Simulation PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_STRING)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
